//--- include/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

////////////////////////////////////////
// Address and block geometry
////////////////////////////////////////

// Byte address width seen at the request port
`define CACHE_ADDR_BITS 32

// 64-byte blocks, so the low 6 bits never reach a directory
`define CACHE_OFFSET_BITS 6

////////////////////////////////////////
// Directory shapes
////////////////////////////////////////

// L1 is small and 2-way
`define CACHE_L1_SETS 16
`define CACHE_L1_INDEX_BITS 4
`define CACHE_L1_WAYS 2

// L2 has four times the sets and twice the ways
`define CACHE_L2_SETS 64
`define CACHE_L2_INDEX_BITS 6
`define CACHE_L2_WAYS 4

// Width of each event counter
`define CACHE_COUNT_BITS 18

// ASCII W marks a write request, anything else is a read
`define CACHE_OP_WRITE 8'h57

`endif

//--- design/cache_pkg.sv
`include "cache_cfg.svh"

package cache_pkg;

  ////////////////////////////////////////
  // Plain vector types
  ////////////////////////////////////////

  // Full byte address of one access
  typedef logic [`CACHE_ADDR_BITS-1:0] addr_t;

  // Operation code as it arrives from the trace
  typedef logic [7:0] op_t;

  // One event counter, wraps silently on overflow
  typedef logic [`CACHE_COUNT_BITS-1:0] count_t;

  ////////////////////////////////////////
  // Structs
  ////////////////////////////////////////

  // Request as held by the controller while the access is in flight
  // The write flag is decoded once from the operation code at acceptance
  typedef struct packed {
    addr_t addr;
    logic  is_write;
  } lookup_req_t;

  // Event counters for one cache level
  // A level counts one read or write per access it sees, and one hit or miss
  typedef struct packed {
    count_t reads;
    count_t writes;
    count_t hits;
    count_t misses;
  } level_stats_t;

  // Counters of both levels, l1 in the upper half
  typedef struct packed {
    level_stats_t l1;
    level_stats_t l2;
  } cache_stats_t;

  ////////////////////////////////////////
  // Controller states
  ////////////////////////////////////////

  // IDLE waits for a request
  // LOOKUP is the cycle in which both directories present their hit result
  // UPDATE is the done cycle, where the directories get their touch or fill
  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    UPDATE
  } ctrl_state_t;

endpackage

//--- design/tag_directory.sv
`include "cache_cfg.svh"

module tag_directory #(
  parameter int SETS = 16,
  parameter int WAYS = 2
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             replace_lru,
  input  logic             lookup,
  input  cache_pkg::addr_t addr,
  input  logic             update,
  output logic             hit
);

  import cache_pkg::*;

  ////////////////////////////////////////
  // Geometry derived from the parameters
  ////////////////////////////////////////

  localparam int ADDR_BITS  = $bits(addr_t);
  localparam int INDEX_BITS = $clog2(SETS);
  localparam int TAG_BITS   = ADDR_BITS - `CACHE_OFFSET_BITS - INDEX_BITS;
  // A direct-mapped directory still needs a one-bit way number
  localparam int WAY_BITS   = (WAYS > 1) ? $clog2(WAYS) : 1;

  typedef logic [INDEX_BITS-1:0] index_t;
  typedef logic [TAG_BITS-1:0]   tag_t;
  typedef logic [WAY_BITS-1:0]   way_t;

  // Address split as latched at the lookup edge
  typedef struct packed {
    index_t index;
    tag_t   tag;
  } key_t;

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  // Each set is an ordered list, way 0 is the newest entry
  // and the last way is the next victim
  tag_t            tag_mem [SETS][WAYS];
  logic [WAYS-1:0] valid_q [SETS];

  // Key of the most recent lookup
  // It stays put until the next lookup so the update can reuse it
  key_t key_q;

  // Per-way compare result and the way that matched
  logic [WAYS-1:0] match;
  way_t            hit_way;

  // move[0] loads the new head, move[w] copies way w-1 into way w
  logic [WAYS-1:0] move;

  ////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////

  // Compare every way of the latched set against the latched tag
  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      match[w] = valid_q[key_q.index][w] && (tag_mem[key_q.index][w] == key_q.tag);
    end
  end

  // Lowest matching way wins, though a fill never creates duplicates
  always_comb begin
    hit_way = '0;
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (match[w]) begin
        hit_way = way_t'(w);
      end
    end
  end

  assign hit = |match;

  ////////////////////////////////////////
  // Touch and fill
  ////////////////////////////////////////

  // On a miss the whole set ages by one and the last entry falls off
  // On an LRU hit only the entries younger than the hit way age, and the hit
  // tag is rewritten at the head
  // A FIFO hit leaves the order alone, so nothing moves
  always_comb begin
    move[0] = update && (!hit || replace_lru);
    for (int w = 1; w < WAYS; w++) begin
      move[w] = move[0] && (!hit || (w <= int'(hit_way)));
    end
  end

  // Tag array, written only through the shift network above
  always_ff @(posedge clk) begin
    if (move[0]) begin
      tag_mem[key_q.index][0] <= key_q.tag;
    end
    for (int w = 1; w < WAYS; w++) begin
      if (move[w]) begin
        tag_mem[key_q.index][w] <= tag_mem[key_q.index][w-1];
      end
    end
  end

  // Valid bits follow the same shift as the tags
  // The lookup key is captured here too, the update above still sees the
  // old key when a new lookup lands on the same edge
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < SETS; s++) begin
        valid_q[s] <= '0;
      end
      key_q <= '0;
    end else begin
      if (lookup) begin
        key_q.index <= addr[`CACHE_OFFSET_BITS +: INDEX_BITS];
        key_q.tag   <= addr[ADDR_BITS-1 -: TAG_BITS];
      end
      if (move[0]) begin
        valid_q[key_q.index][0] <= 1'b1;
      end
      for (int w = 1; w < WAYS; w++) begin
        if (move[w]) begin
          valid_q[key_q.index][w] <= valid_q[key_q.index][w-1];
        end
      end
    end
  end

endmodule

//--- design/access_controller.sv
`include "cache_cfg.svh"

module access_controller (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    req_valid,
  input  cache_pkg::addr_t        req_addr,
  input  cache_pkg::op_t          req_op,
  input  logic                    l1_hit_in,
  input  logic                    l2_hit_in,
  output logic                    lookup,
  output cache_pkg::addr_t        lookup_addr,
  output logic                    l1_update,
  output logic                    l2_update,
  output logic                    busy,
  output logic                    done,
  output logic                    l1_hit,
  output logic                    l2_hit,
  output cache_pkg::cache_stats_t stats
);

  import cache_pkg::*;

  ctrl_state_t state_q;
  ctrl_state_t state_d;

  // Request held for the duration of the access
  lookup_req_t req_q;

  // A request is taken whenever no lookup is in progress,
  // which includes the done cycle of the previous access
  logic accept;

  ////////////////////////////////////////
  // Counter update for one level
  ////////////////////////////////////////

  // Returns the counters of one level after it has seen one access
  function automatic level_stats_t count_access(level_stats_t cur, logic is_write,
                                                logic was_hit);
    level_stats_t nxt;
    nxt = cur;
    if (is_write) begin
      nxt.writes = cur.writes + count_t'(1);
    end else begin
      nxt.reads = cur.reads + count_t'(1);
    end
    if (was_hit) begin
      nxt.hits = cur.hits + count_t'(1);
    end else begin
      nxt.misses = cur.misses + count_t'(1);
    end
    return nxt;
  endfunction

  ////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////

  assign accept = req_valid && (state_q != LOOKUP);

  // Back-to-back requests go from UPDATE straight into LOOKUP
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (req_valid) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        state_d = UPDATE;
      end
      UPDATE: begin
        state_d = req_valid ? LOOKUP : IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // Directories latch the address on the accept edge itself,
  // so their hit flags are ready during LOOKUP
  assign lookup      = accept;
  assign lookup_addr = accept ? req_addr : req_q.addr;

  assign busy = (state_q == LOOKUP);
  assign done = (state_q == UPDATE);

  // L1 always learns the access; L2 only sees traffic that missed L1
  assign l1_update = done;
  assign l2_update = done && !l1_hit;

  // Control state, hit flags and counters
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= IDLE;
      l1_hit  <= 1'b0;
      l2_hit  <= 1'b0;
      stats   <= '0;
    end else begin
      state_q <= state_d;
      // Both results are final at the end of LOOKUP, so record and count them
      if (state_q == LOOKUP) begin
        l1_hit   <= l1_hit_in;
        l2_hit   <= l2_hit_in;
        stats.l1 <= count_access(stats.l1, req_q.is_write, l1_hit_in);
        if (!l1_hit_in) begin
          stats.l2 <= count_access(stats.l2, req_q.is_write, l2_hit_in);
        end
      end
    end
  end

  // Captured request, only loaded on acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      req_q.addr     <= req_addr;
      req_q.is_write <= (req_op == `CACHE_OP_WRITE);
    end
  end

endmodule

//--- design/cache_sim_top.sv
`include "cache_cfg.svh"

module cache_sim_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    replace_lru,
  input  logic                    req_valid,
  input  cache_pkg::addr_t        req_addr,
  input  cache_pkg::op_t          req_op,
  output logic                    busy,
  output logic                    done,
  output logic                    l1_hit,
  output logic                    l2_hit,
  output cache_pkg::cache_stats_t stats
);

  import cache_pkg::*;

  ////////////////////////////////////////
  // Internal wiring
  ////////////////////////////////////////

  // Shared lookup strobe and address for both levels
  logic  lookup;
  addr_t lookup_addr;

  // Raw hit flags straight from the directories
  logic l1_dir_hit;
  logic l2_dir_hit;

  // Each level has its own update strobe because L2 is skipped when L1 hit
  logic l1_update;
  logic l2_update;

  ////////////////////////////////////////
  // Directories
  ////////////////////////////////////////

  // Both levels look up the same address in parallel
  tag_directory #(
    .SETS (`CACHE_L1_SETS),
    .WAYS (`CACHE_L1_WAYS)
  ) l1_dir (
    .clk         (clk),
    .reset       (reset),
    .replace_lru (replace_lru),
    .lookup      (lookup),
    .addr        (lookup_addr),
    .update      (l1_update),
    .hit         (l1_dir_hit)
  );

  tag_directory #(
    .SETS (`CACHE_L2_SETS),
    .WAYS (`CACHE_L2_WAYS)
  ) l2_dir (
    .clk         (clk),
    .reset       (reset),
    .replace_lru (replace_lru),
    .lookup      (lookup),
    .addr        (lookup_addr),
    .update      (l2_update),
    .hit         (l2_dir_hit)
  );

  ////////////////////////////////////////
  // Sequencing and statistics
  ////////////////////////////////////////

  access_controller ctrl (
    .clk         (clk),
    .reset       (reset),
    .req_valid   (req_valid),
    .req_addr    (req_addr),
    .req_op      (req_op),
    .l1_hit_in   (l1_dir_hit),
    .l2_hit_in   (l2_dir_hit),
    .lookup      (lookup),
    .lookup_addr (lookup_addr),
    .l1_update   (l1_update),
    .l2_update   (l2_update),
    .busy        (busy),
    .done        (done),
    .l1_hit      (l1_hit),
    .l2_hit      (l2_hit),
    .stats       (stats)
  );

endmodule

//--- testbench/tb_clock_gen.sv
module tb_clock_gen #(
  parameter int PERIOD = 40
) (
  output logic clk
);

  // Free-running clock, low for the first half period
  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2) clk = ~clk;
    end
  end

endmodule

//--- testbench/cache_sim_tb.sv
`include "cache_cfg.svh"

module cache_sim_tb;

  import cache_pkg::*;

  ////////////////////////////////////////
  // Run length and address patterns
  ////////////////////////////////////////

  localparam int RESET_CYCLES   = 10;
  localparam int RANDOM_COUNT   = 300;
  localparam int DIRECTED_COUNT = 20;
  localparam int RESET_COUNT    = 5;
  // Each access takes at most three cycles including an idle gap
  localparam int SEQ_CYCLES     = RESET_COUNT * (RESET_CYCLES + 1)
                                  + 3 * (DIRECTED_COUNT + 2 * RANDOM_COUNT);
  localparam int TIMEOUT_CYCLES = 3 * SEQ_CYCLES;
  localparam int BLK_BITS       = `CACHE_ADDR_BITS - `CACHE_OFFSET_BITS;
  localparam addr_t RANDOM_BASE = 32'h7ff0_0000;
  localparam op_t OP_READ       = 8'h52;

  typedef logic [BLK_BITS-1:0] blk_t;

  // One set of the reference model, position 0 is the newest entry
  typedef struct packed {
    logic [3:0]               valid;
    logic [3:0][BLK_BITS-1:0] blk;
  } set_t;

  // Everything the DUT reports at the end of one access
  typedef struct packed {
    logic         l1_hit;
    logic         l2_hit;
    cache_stats_t stats;
  } result_t;

  logic         clk;
  logic         reset;
  logic         replace_lru;
  logic         req_valid;
  addr_t        req_addr;
  op_t          req_op;
  logic         busy;
  logic         done;
  logic         l1_hit;
  logic         l2_hit;
  cache_stats_t stats;

  // Reference model state and the results still waiting for their done
  set_t         l1_model [`CACHE_L1_SETS];
  set_t         l2_model [`CACHE_L2_SETS];
  cache_stats_t model_stats;
  result_t      exp_q [$];

  logic [31:0] lfsr_state;
  addr_t       last_addr;
  int          cycle_count;

  tb_clock_gen #(.PERIOD(40)) clock_gen (.clk(clk));

  cache_sim_top dut (
    .clk         (clk),
    .reset       (reset),
    .replace_lru (replace_lru),
    .req_valid   (req_valid),
    .req_addr    (req_addr),
    .req_op      (req_op),
    .busy        (busy),
    .done        (done),
    .l1_hit      (l1_hit),
    .l2_hit      (l2_hit),
    .stats       (stats)
  );

  ////////////////////////////////////////
  // Reporting and compare tasks
  ////////////////////////////////////////

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      fail_run($sformatf("ERR t=%0t %s expected %0b actual %0b", $time, name, expected,
                         actual));
    end
  endtask

  task automatic check_count(input string name, input count_t expected, input count_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("ERR t=%0t %s expected %0d actual %0d", $time, name, expected,
                         actual));
    end
  endtask

  task automatic check_stats(input string name, input cache_stats_t expected,
                             input cache_stats_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("ERR t=%0t %s expected %h actual %h", $time, name, expected, actual));
    end
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Position of a block in a set, or -1 when it is absent
  function automatic int find_way(set_t s, int ways, blk_t blk);
    int found;
    found = -1;
    for (int w = ways - 1; w >= 0; w--) begin
      if (s.valid[w] && (s.blk[w] == blk)) begin
        found = w;
      end
    end
    return found;
  endfunction

  // LRU brings the hit block to the front, FIFO keeps the order
  function automatic set_t touch_set(set_t s, int way, logic lru);
    set_t n;
    n = s;
    if (lru) begin
      for (int w = 1; w <= way; w++) begin
        n.blk[w]   = s.blk[w-1];
        n.valid[w] = s.valid[w-1];
      end
      n.blk[0]   = s.blk[way];
      n.valid[0] = 1'b1;
    end
    return n;
  endfunction

  // Everything ages by one, the oldest falls off and the new block leads
  function automatic set_t fill_set(set_t s, int ways, blk_t blk);
    set_t n;
    n = s;
    for (int w = 1; w < ways; w++) begin
      n.blk[w]   = s.blk[w-1];
      n.valid[w] = s.valid[w-1];
    end
    n.blk[0]   = blk;
    n.valid[0] = 1'b1;
    return n;
  endfunction

  // Applies one access to both model levels and returns the expected outputs
  function automatic result_t model_access(addr_t addr, logic is_write, logic lru);
    result_t r;
    blk_t    blk;
    int      i1;
    int      i2;
    int      w1;
    int      w2;
    blk = addr[`CACHE_ADDR_BITS-1:`CACHE_OFFSET_BITS];
    i1  = int'(addr[`CACHE_OFFSET_BITS +: `CACHE_L1_INDEX_BITS]);
    i2  = int'(addr[`CACHE_OFFSET_BITS +: `CACHE_L2_INDEX_BITS]);
    w1  = find_way(l1_model[i1], `CACHE_L1_WAYS, blk);
    w2  = find_way(l2_model[i2], `CACHE_L2_WAYS, blk);
    r.l1_hit = (w1 >= 0);
    r.l2_hit = (w2 >= 0);
    // L1 sees every access
    if (is_write) model_stats.l1.writes = model_stats.l1.writes + 1'b1;
    else model_stats.l1.reads = model_stats.l1.reads + 1'b1;
    if (r.l1_hit) model_stats.l1.hits = model_stats.l1.hits + 1'b1;
    else model_stats.l1.misses = model_stats.l1.misses + 1'b1;
    if (r.l1_hit) begin
      l1_model[i1] = touch_set(l1_model[i1], w1, lru);
    end else begin
      // Only L1 misses go on to L2, which is touched or filled
      l1_model[i1] = fill_set(l1_model[i1], `CACHE_L1_WAYS, blk);
      if (is_write) model_stats.l2.writes = model_stats.l2.writes + 1'b1;
      else model_stats.l2.reads = model_stats.l2.reads + 1'b1;
      if (r.l2_hit) begin
        model_stats.l2.hits = model_stats.l2.hits + 1'b1;
        l2_model[i2] = touch_set(l2_model[i2], w2, lru);
      end else begin
        model_stats.l2.misses = model_stats.l2.misses + 1'b1;
        l2_model[i2] = fill_set(l2_model[i2], `CACHE_L2_WAYS, blk);
      end
    end
    r.stats = model_stats;
    return r;
  endfunction

  ////////////////////////////////////////
  // Random source
  ////////////////////////////////////////

  // Taps 32, 22, 2 and 1 give a maximal-length sequence
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // Four L1 sets, two L2 sets per L1 set and eight tags, with a quarter of
  // the accesses repeating the previous address
  task automatic next_random_addr(output addr_t a);
    logic [31:0] b;
    draw_bits(2, b);
    if (b[1:0] == 2'b00) begin
      a = last_addr;
    end else begin
      a = RANDOM_BASE;
      draw_bits(3, b);
      a[14:12] = b[2:0];
      draw_bits(1, b);
      a[10] = b[0];
      draw_bits(2, b);
      a[7:6] = b[1:0];
      draw_bits(6, b);
      a[5:0] = b[5:0];
    end
    last_addr = a;
  endtask

  ////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////

  // Entered one unit after a rising edge, returns in the done cycle
  // With stray set, a second request sits on the port through the busy cycle
  // and the DUT has to ignore it
  task automatic send_access(input addr_t a, input op_t op, input logic stray = 1'b0);
    req_valid = 1'b1;
    req_addr  = a;
    req_op    = op;
    exp_q.push_back(model_access(a, op == `CACHE_OP_WRITE, replace_lru));
    @(posedge clk);
    #1;
    // Same sets as the real request but another tag in both levels
    req_valid = stray;
    req_addr  = a ^ 32'h0000_7000;
    check_bit("busy", 1'b1, busy);
    check_bit("done", 1'b0, done);
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    check_bit("busy", 1'b0, busy);
    check_bit("done", 1'b1, done);
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #1;
    check_bit("busy", 1'b0, busy);
    check_bit("done", 1'b0, done);
  endtask

  // Resets DUT and model together and checks the power-on state
  task automatic apply_reset();
    if (exp_q.size() != 0) begin
      fail_run("Reset requested while access results were still outstanding");
    end
    reset     = 1'b1;
    req_valid = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int s = 0; s < `CACHE_L1_SETS; s++) l1_model[s] = '0;
    for (int s = 0; s < `CACHE_L2_SETS; s++) l2_model[s] = '0;
    model_stats = '0;
    check_bit("busy", 1'b0, busy);
    check_bit("done", 1'b0, done);
    check_bit("l1_hit", 1'b0, l1_hit);
    check_bit("l2_hit", 1'b0, l2_hit);
    check_stats("stats", '0, stats);
  endtask

  // Touch X between two fills so that only LRU keeps it in L1 set 3
  task automatic run_policy_contrast(input logic lru);
    replace_lru = lru;
    apply_reset();
    send_access(32'h2000_00c0, OP_READ);
    send_access(32'h2000_04c0, OP_READ);
    send_access(32'h2000_00c0, OP_READ);
    check_bit("l1_hit", 1'b1, l1_hit);
    send_access(32'h2000_08c0, OP_READ);
    send_access(32'h2000_00c0, OP_READ);
    check_bit("l1_hit", lru, l1_hit);
    check_bit("l2_hit", 1'b1, l2_hit);
    idle_cycle();
  endtask

  // Mostly back-to-back requests with an occasional idle cycle
  task automatic run_random(input logic lru);
    addr_t       a;
    op_t         op;
    logic [31:0] b;
    logic        stray;
    replace_lru = lru;
    apply_reset();
    for (int i = 0; i < RANDOM_COUNT; i++) begin
      next_random_addr(a);
      draw_bits(1, b);
      if (b[0]) begin
        op = `CACHE_OP_WRITE;
      end else begin
        draw_bits(8, b);
        op = b[7:0];
      end
      draw_bits(1, b);
      stray = b[0];
      send_access(a, op, stray);
      draw_bits(2, b);
      if (b[1:0] == 2'b00) idle_cycle();
    end
    idle_cycle();
  endtask

  ////////////////////////////////////////
  // Result checking and run limit
  ////////////////////////////////////////

  // Outputs are settled by the falling edge of the done cycle
  always @(negedge clk) begin : compare_results
    result_t expected;
    if (!reset && done) begin
      if (exp_q.size() == 0) begin
        fail_run("Done was raised although no access was outstanding");
      end else begin
        expected = exp_q.pop_front();
        check_bit("l1_hit", expected.l1_hit, l1_hit);
        check_bit("l2_hit", expected.l2_hit, l2_hit);
        check_stats("stats", expected.stats, stats);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      fail_run($sformatf("Timeout after %0d cycles before the test sequence ended",
                         cycle_count));
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    cycle_count = 0;
    lfsr_state  = 32'ha03bf179;
    last_addr   = RANDOM_BASE;
    reset       = 1'b1;
    replace_lru = 1'b0;
    req_valid   = 1'b0;
    req_addr    = '0;
    req_op      = '0;
    apply_reset();

    // A cold access misses both levels, the repeat hits L1 only
    send_access(32'h0000_1004, OP_READ);
    check_bit("l1_hit", 1'b0, l1_hit);
    check_bit("l2_hit", 1'b0, l2_hit);
    idle_cycle();
    send_access(32'h0000_1004, OP_READ);
    check_bit("l1_hit", 1'b1, l1_hit);
    check_count("stats.l1.reads", count_t'(2), stats.l1.reads);
    check_count("stats.l1.hits", count_t'(1), stats.l1.hits);
    check_count("stats.l2.reads", count_t'(1), stats.l2.reads);
    idle_cycle();
    send_access(32'h0000_1004, `CACHE_OP_WRITE);
    check_count("stats.l1.writes", count_t'(1), stats.l1.writes);
    check_count("stats.l2.writes", count_t'(0), stats.l2.writes);
    idle_cycle();

    // Two more blocks of L1 set 0 push the first one out of L1 but not L2
    send_access(32'h0000_1400, OP_READ);
    send_access(32'h0000_1838, OP_READ);
    send_access(32'h0000_1000, OP_READ);
    check_bit("l1_hit", 1'b0, l1_hit);
    check_bit("l2_hit", 1'b1, l2_hit);
    send_access(32'h0000_1000, OP_READ);
    check_bit("l1_hit", 1'b1, l1_hit);
    idle_cycle();

    run_policy_contrast(1'b0);
    run_policy_contrast(1'b1);
    run_random(1'b0);
    run_random(1'b1);

    if (exp_q.size() != 0) begin
      fail_run("Some accesses never reported done");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

//--- all.f
+incdir+include
design/cache_pkg.sv
design/tag_directory.sv
design/access_controller.sv
design/cache_sim_top.sv
testbench/tb_clock_gen.sv
testbench/cache_sim_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module cache_sim_tb \
  --Mdir obj_dir -o cache_sim_tb_bin

output=$(./obj_dir/cache_sim_tb_bin 2>&1) || true
echo "$output"

if grep -q "ALL CHECKS PASSED" <<< "$output"; then
  exit 0
fi
echo "Simulation did not pass"
exit 1
